// File: hw/pool_macros.svh
`ifndef POOL_MACROS_SVH
`define POOL_MACROS_SVH

// Width of one feature-map pixel
`define POOL_PIX_W 8

// Pixel pairs per row, also the depth of each line buffer
`define POOL_LINE_DEPTH 13

`endif

// File: hw/pool_pkg.sv
package pool_pkg;

  // Comparator select, held per row pair
  typedef enum logic {
    POOL_MAX = 1'b0,
    POOL_MIN = 1'b1
  } pool_mode_e;

  // Output burst controller states
  typedef enum logic [1:0] {
    WB_IDLE  = 2'b00,
    WB_DRAIN = 2'b01,
    WB_DONE  = 2'b10
  } wb_state_e;

endpackage

// File: hw/pool_ctrl_if.sv
`timescale 1ns/1ns

interface pool_ctrl_if import pool_pkg::*; ();

  logic       en_h;      // Horizontal reduce, line buffer 1 shift
  logic       en_v;      // Vertical combine, line buffer 2 shift
  pool_mode_e mode;      // Mode for the current row pair
  logic       row_done;  // Odd row complete

  modport seq (output en_h, output en_v, output mode, output row_done);

  modport dp (input en_h, input en_v, input mode);

  modport wb (input row_done, input en_v);

endinterface

// File: hw/pool_compare.sv
`timescale 1ns/1ns

`include "pool_macros.svh"

module pool_compare import pool_pkg::*; (
  input  logic [`POOL_PIX_W-1:0] a,
  input  logic [`POOL_PIX_W-1:0] b,
  input  pool_mode_e             sel,
  input  logic                   en,
  output logic [`POOL_PIX_W-1:0] out
);

  logic a_larger;

  assign a_larger = (a > b);  // Unsigned pixel compare

  always_comb begin
    if (!en) begin
      out = '0;  // Idle output is forced low
    end else if (sel == POOL_MAX) begin
      out = a_larger ? a : b;
    end else begin
      out = a_larger ? b : a;
    end
  end

endmodule

// File: hw/line_shift_buf.sv
`timescale 1ns/1ns

`include "pool_macros.svh"

module line_shift_buf #(
  parameter int WIDTH = `POOL_PIX_W,
  parameter int DEPTH = `POOL_LINE_DEPTH
) (
  input  logic             clk,
  input  logic             shift_en,
  input  logic [WIDTH-1:0] din,
  output logic [WIDTH-1:0] dout
);

  logic [WIDTH-1:0] stage [DEPTH];  // stage[0] is the newest entry

  always_ff @(posedge clk) begin
    if (shift_en) begin
      stage[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage[i] <= stage[i-1];
      end
    end
  end

  // Oldest entry, written DEPTH shifts ago
  assign dout = stage[DEPTH-1];

endmodule

// File: hw/pool_row_seq.sv
`timescale 1ns/1ns

`include "pool_macros.svh"

module pool_row_seq import pool_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       pix_valid,
  input  pool_mode_e pool_mode,
  input  logic       busy,
  pool_ctrl_if.seq   ctrl
);

  localparam int CNT_W = $clog2(`POOL_LINE_DEPTH);

  logic [CNT_W-1:0] pair_cnt;   // Pair index within the row
  logic             odd_row;    // Row parity, set on the second row of a pair
  pool_mode_e       mode_q;     // Mode held for the row pair
  logic             last_pair;
  logic             take_mode;

  assign last_pair = pix_valid && (pair_cnt == CNT_W'(`POOL_LINE_DEPTH - 1));
  assign take_mode = pix_valid && !odd_row && (pair_cnt == '0);

  assign ctrl.en_h = pix_valid;
  assign ctrl.en_v = pix_valid && odd_row;

  // The first pair of an even row already reduces with the new mode,
  // later pairs of the row pair use the held copy
  assign ctrl.mode = take_mode ? pool_mode : mode_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pair_cnt      <= '0;
      odd_row       <= 1'b0;
      mode_q        <= POOL_MAX;
      ctrl.row_done <= 1'b0;
    end else begin
      ctrl.row_done <= last_pair && odd_row;  // Single-cycle pulse
      if (take_mode) begin
        mode_q <= pool_mode;
      end
      if (pix_valid) begin
        if (last_pair) begin
          pair_cnt <= '0;
          odd_row  <= ~odd_row;  // Next row of the pair
        end else begin
          pair_cnt <= pair_cnt + 1'b1;
        end
      end
    end
  end

  // The source holds off while the output burst runs
  a_no_pix_when_busy: assert property (
    @(posedge clk) disable iff (rst) busy |-> !pix_valid
  );

endmodule

// File: hw/pool_writeback.sv
`timescale 1ns/1ns

`include "pool_macros.svh"

module pool_writeback import pool_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  pool_ctrl_if.wb                ctrl,
  input  logic [`POOL_PIX_W-1:0] head,
  output logic                   buf_shift,
  output logic [`POOL_PIX_W-1:0] out_data,
  output logic                   out_valid,
  output logic                   busy
);

  localparam int CNT_W = $clog2(`POOL_LINE_DEPTH);

  wb_state_e        state;
  wb_state_e        state_nxt;
  logic [CNT_W-1:0] beat_cnt;   // Beats sent in the current burst
  logic             draining;
  logic             last_beat;

  assign draining  = (state == WB_DRAIN);
  assign last_beat = draining && (beat_cnt == CNT_W'(`POOL_LINE_DEPTH - 1));

  // Buffer 2 shifts on fill during the odd row and on drain here
  assign buf_shift = ctrl.en_v | draining;
  assign busy      = (state != WB_IDLE);

  always_comb begin
    case (state)
      WB_IDLE:  state_nxt = ctrl.row_done ? WB_DRAIN : WB_IDLE;
      WB_DRAIN: state_nxt = last_beat ? WB_DONE : WB_DRAIN;
      WB_DONE:  state_nxt = WB_IDLE;  // One cycle of trailing busy
      default:  state_nxt = WB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= WB_IDLE;
      beat_cnt  <= '0;
      out_valid <= 1'b0;
    end else begin
      state     <= state_nxt;
      out_valid <= draining;
      if (draining) begin
        beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (draining) begin
      out_data <= head;  // Column order, oldest first
    end
  end

  // A new row pair cannot complete while the previous burst is out
  a_row_done_idle: assert property (
    @(posedge clk) disable iff (rst) ctrl.row_done |-> state == WB_IDLE
  );

  a_burst_len: assert property (
    @(posedge clk) disable iff (rst)
      $rose(out_valid) |-> ##[1:`POOL_LINE_DEPTH] !out_valid
  );

endmodule

// File: hw/pool_top.sv
`timescale 1ns/1ns

`include "pool_macros.svh"

module pool_top import pool_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`POOL_PIX_W-1:0] pix_a,
  input  logic [`POOL_PIX_W-1:0] pix_b,
  input  logic                   pix_valid,
  input  pool_mode_e             pool_mode,
  output logic [`POOL_PIX_W-1:0] out_data,
  output logic                   out_valid,
  output logic                   busy
);

  logic [`POOL_PIX_W-1:0] h_out;     // Pair reduced horizontally
  logic [`POOL_PIX_W-1:0] v_out;     // Pooled 2x2 value
  logic [`POOL_PIX_W-1:0] lb1_head;  // Same column, row above
  logic [`POOL_PIX_W-1:0] lb2_head;
  logic                   lb2_shift;

  pool_ctrl_if ctrl ();

  pool_row_seq i_seq (
    .clk       (clk),
    .rst       (rst),
    .pix_valid (pix_valid),
    .pool_mode (pool_mode),
    .busy      (busy),
    .ctrl      (ctrl.seq)
  );

  pool_compare i_cmp_h (
    .a   (pix_a),
    .b   (pix_b),
    .sel (ctrl.mode),
    .en  (ctrl.en_h),
    .out (h_out)
  );

  line_shift_buf #(
    .WIDTH (`POOL_PIX_W),
    .DEPTH (`POOL_LINE_DEPTH)
  ) i_lb1 (
    .clk      (clk),
    .shift_en (ctrl.en_h),
    .din      (h_out),
    .dout     (lb1_head)
  );

  pool_compare i_cmp_v (
    .a   (lb1_head),
    .b   (h_out),
    .sel (ctrl.mode),
    .en  (ctrl.en_v),
    .out (v_out)
  );

  line_shift_buf #(
    .WIDTH (`POOL_PIX_W),
    .DEPTH (`POOL_LINE_DEPTH)
  ) i_lb2 (
    .clk      (clk),
    .shift_en (lb2_shift),
    .din      (v_out),
    .dout     (lb2_head)
  );

  pool_writeback i_wb (
    .clk       (clk),
    .rst       (rst),
    .ctrl      (ctrl.wb),
    .head      (lb2_head),
    .buf_shift (lb2_shift),
    .out_data  (out_data),
    .out_valid (out_valid),
    .busy      (busy)
  );

endmodule

// File: test/tb_clk_gen.sv
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD     = 8,
  parameter int RST_CYCLES = 4
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released on a rising edge, so the DUT sees RST_CYCLES edges in reset
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// File: test/tb_pool_top.sv
`timescale 1ns/1ns

`include "pool_macros.svh"

module tb_pool_top import pool_pkg::*; ();

  localparam int PIX_W     = `POOL_PIX_W;
  localparam int DEPTH     = `POOL_LINE_DEPTH;
  localparam int NUM_CASES = 6;
  localparam int MAX_GAP   = 3;  // Two LFSR bits per gap
  localparam int TIMEOUT   = NUM_CASES * (2 * DEPTH * (1 + MAX_GAP) + DEPTH + 4) + 50;

  typedef struct packed {
    pool_mode_e mode;      // Mode at the first pair of the even row
    pool_mode_e odd_mode;  // Driven during the odd row and ignored
    logic       gaps;      // Random idle cycles between pairs
  } case_t;

  // Modes alternate so each row pair follows one of the other kind
  localparam case_t CASES [NUM_CASES] = '{
    '{POOL_MAX, POOL_MAX, 1'b0},
    '{POOL_MIN, POOL_MIN, 1'b0},
    '{POOL_MAX, POOL_MIN, 1'b0},
    '{POOL_MIN, POOL_MAX, 1'b1},
    '{POOL_MAX, POOL_MAX, 1'b1},
    '{POOL_MIN, POOL_MIN, 1'b1}
  };

  logic             clk;
  logic             rst;
  logic [PIX_W-1:0] pix_a;
  logic [PIX_W-1:0] pix_b;
  logic             pix_valid;
  pool_mode_e       pool_mode;
  logic [PIX_W-1:0] out_data;
  logic             out_valid;
  logic             busy;

  logic [15:0]      lfsr_q = 16'd62526;
  logic [PIX_W-1:0] exp_q [$];     // Expected pooled values in column order
  logic [PIX_W-1:0] even_a [DEPTH];
  logic [PIX_W-1:0] even_b [DEPTH];
  int               run_len = 0;   // Beats in the current burst
  int               cycle_cnt = 0;

  tb_clk_gen #(
    .PERIOD     (8),
    .RST_CYCLES (4)
  ) i_clk_gen (
    .clk (clk),
    .rst (rst)
  );

  pool_top i_dut (
    .clk       (clk),
    .rst       (rst),
    .pix_a     (pix_a),
    .pix_b     (pix_b),
    .pix_valid (pix_valid),
    .pool_mode (pool_mode),
    .out_data  (out_data),
    .out_valid (out_valid),
    .busy      (busy)
  );

  task automatic report_failure(input string text);
    $display("%s", text);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_value(input string name, input logic [PIX_W-1:0] exp,
                              input logic [PIX_W-1:0] got);
    report_failure($sformatf("error: %s expected 0x%0h, got 0x%0h", name, exp, got));
  endtask

  // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [7:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val    = {val[6:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  // Reference 2x2 window picks the largest or smallest of four pixels
  function automatic logic [PIX_W-1:0] pool_window(input pool_mode_e mode,
      input logic [PIX_W-1:0] p0, input logic [PIX_W-1:0] p1,
      input logic [PIX_W-1:0] p2, input logic [PIX_W-1:0] p3);
    logic [PIX_W-1:0] win [4];
    logic [PIX_W-1:0] res;
    win = '{p0, p1, p2, p3};
    res = p0;
    for (int i = 1; i < 4; i++) begin
      if ((mode == POOL_MAX) ? (win[i] > res) : (win[i] < res)) begin
        res = win[i];
      end
    end
    return res;
  endfunction

  task automatic send_pair(input logic [PIX_W-1:0] a, input logic [PIX_W-1:0] b,
                           input pool_mode_e mode, input logic idle_check);
    @(negedge clk);
    if (idle_check) begin
      assert (out_valid === 1'b0) else report_value("out_valid", '0, out_valid);
      assert (busy === 1'b0) else report_value("busy", '0, busy);
    end
    while (busy) begin  // Source stalls during the output burst
      pix_valid = 1'b0;
      @(negedge clk);
    end
    pix_a     = a;
    pix_b     = b;
    pool_mode = mode;
    pix_valid = 1'b1;
  endtask

  task automatic idle_gap(input int n);
    repeat (n) begin
      @(negedge clk);
      pix_valid = 1'b0;
    end
  endtask

  initial begin
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] gap;
    pool_mode_e m;
    pix_a     = '0;
    pix_b     = '0;
    pix_valid = 1'b0;
    pool_mode = POOL_MAX;
    @(negedge clk);
    while (rst) @(negedge clk);
    for (int c = 0; c < NUM_CASES; c++) begin
      for (int row = 0; row < 2; row++) begin
        m = (row == 0) ? CASES[c].mode : CASES[c].odd_mode;
        for (int p = 0; p < DEPTH; p++) begin
          take_bits(PIX_W, a);
          take_bits(PIX_W, b);
          gap = '0;
          if (CASES[c].gaps) begin
            take_bits(2, gap);
          end
          if (row == 0) begin
            even_a[p] = a;
            even_b[p] = b;
          end else begin
            exp_q.push_back(pool_window(CASES[c].mode, even_a[p], even_b[p], a, b));
          end
          send_pair(a, b, m, (c == 0) && (row == 0));
          idle_gap(gap);
        end
      end
    end
    @(negedge clk);
    pix_valid = 1'b0;
    while (busy || out_valid || exp_q.size() != 0) @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

  // Output monitor samples away from the rising edge
  always @(negedge clk) begin
    logic [PIX_W-1:0] exp;
    if (!rst) begin
      if (out_valid) begin
        assert (busy) else report_failure("busy was low during an output beat");
        assert (run_len < DEPTH) else report_failure("output burst longer than one row");
        assert (exp_q.size() > 0) else report_failure("extra output beat with nothing expected");
        exp = exp_q.pop_front();
        assert (out_data === exp) else report_value("out_data", exp, out_data);
        run_len = run_len + 1;
      end else if (run_len != 0) begin
        assert (run_len == DEPTH) else
          report_failure($sformatf("output burst had %0d beats instead of %0d",
                                   run_len, DEPTH));
        run_len = 0;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      report_failure($sformatf("timeout after %0d cycles with %0d expected beats not seen",
                               cycle_cnt, exp_q.size()));
    end
  end

endmodule

// File: sim.f
+incdir+hw
hw/pool_pkg.sv
hw/pool_ctrl_if.sv
hw/pool_compare.sv
hw/line_shift_buf.sv
hw/pool_row_seq.sv
hw/pool_writeback.sv
hw/pool_top.sv
test/tb_clk_gen.sv
test/tb_pool_top.sv

// File: Bender.yml
package:
  name: pool_unit

sources:
  - include_dirs:
      - hw
    files:
      - hw/pool_pkg.sv
      - hw/pool_ctrl_if.sv
      - hw/pool_compare.sv
      - hw/line_shift_buf.sv
      - hw/pool_row_seq.sv
      - hw/pool_writeback.sv
      - hw/pool_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/tb_clk_gen.sv
      - test/tb_pool_top.sv
